// ==== verilog/ppu_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths and constants for the picture processor register side
// Scanline 511 stands for the pre-render line (-1 in 9 bits)
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package ppu_pkg;

	typedef logic [7:0]  byte_t;      // CPU data bus
	typedef logic [2:0]  reg_sel_t;   // Register index from CPU address
	typedef logic [8:0]  line_pos_t;  // Scanline or cycle number
	typedef logic [14:0] vaddr_t;     // Current / temporary address
	typedef logic [2:0]  fine_x_t;    // Fine X scroll
	typedef logic [4:0]  pal_index_t; // Palette address
	typedef logic [5:0]  colour_t;    // Palette entry

	typedef enum logic [1:0] {
		SYS_NTSC  = 2'd0,
		SYS_PAL   = 2'd1,
		SYS_DENDY = 2'd2,
		SYS_VS    = 2'd3
	} sys_type_t;

	// Register map
	localparam reg_sel_t REG_CTRL   = 3'd0;
	localparam reg_sel_t REG_MASK   = 3'd1;
	localparam reg_sel_t REG_STATUS = 3'd2;
	localparam reg_sel_t REG_SCROLL = 3'd5;
	localparam reg_sel_t REG_ADDR   = 3'd6;
	localparam reg_sel_t REG_DATA   = 3'd7;

	// Frame timing
	localparam line_pos_t LAST_CYCLE          = 9'd340;
	localparam line_pos_t PRE_RENDER_LINE     = 9'd511;
	localparam line_pos_t VISIBLE_LINES       = 9'd240;
	localparam line_pos_t VBLANK_START_NORMAL = 9'd241; // NTSC, PAL, Vs
	localparam line_pos_t VBLANK_START_DENDY  = 9'd291;
	localparam line_pos_t VBLANK_END_NTSC     = 9'd260; // NTSC, Vs
	localparam line_pos_t VBLANK_END_LONG     = 9'd310; // PAL, Dendy

	localparam logic [5:0] PALETTE_PAGE = 6'h3F;    // Address bits 13:8 of palette space
	localparam int PALETTE_ENTRIES      = 32;
	localparam vaddr_t STEP_ACROSS      = 15'd1;
	localparam vaddr_t STEP_DOWN        = 15'd32;

endpackage

// ==== verilog/ppu_reg_port.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU register decode, one pulse per register access
// read and write must never be high together
// Only increment, NMI enable and render enables are kept
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module ppu_reg_port
	import ppu_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  reg_sel_t ain,
	input  byte_t    din,
	input  logic     read,
	input  logic     write,
	output logic     ctrl_wr,
	output logic     scroll_wr,
	output logic     addr_wr,
	output logic     data_wr,
	output logic     data_rd,
	output logic     status_rd,
	output logic     incr_32,
	output logic     vbl_enable,
	output logic     rendering_enabled
);

	logic mask_wr;
	logic bg_enable;  // Mask bit 3
	logic spr_enable; // Mask bit 4

	// Strobe decode
	assign ctrl_wr   = write && (ain == REG_CTRL);
	assign mask_wr   = write && (ain == REG_MASK);
	assign scroll_wr = write && (ain == REG_SCROLL);
	assign addr_wr   = write && (ain == REG_ADDR);
	assign data_wr   = write && (ain == REG_DATA);
	assign data_rd   = read && (ain == REG_DATA);
	assign status_rd = read && (ain == REG_STATUS);

	always_ff @(posedge clk) begin
		if (reset) begin
			incr_32           <= 1'b0;
			vbl_enable        <= 1'b0;
			bg_enable         <= 1'b0;
			spr_enable        <= 1'b0;
			rendering_enabled <= 1'b0;
		end else begin
			if (ctrl_wr) begin
				incr_32    <= din[2]; // 0 steps by 1, 1 steps by 32
				vbl_enable <= din[7];
			end
			if (mask_wr) begin
				bg_enable  <= din[3];
				spr_enable <= din[4];
			end
			// One extra cycle behind the mask bits, as on the real chip
			rendering_enabled <= bg_enable | spr_enable;
		end
	end

endmodule

// ==== verilog/ppu_frame_timer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One clock is one pixel, no clock enable
// Odd frames drop a pixel on the pre-render line (NTSC and Vs, rendering on)
// Vblank pulses are one cycle wide at cycle 0
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module ppu_frame_timer
	import ppu_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  sys_type_t sys_type,
	input  logic      rendering_enabled,
	output line_pos_t scanline,
	output line_pos_t cycle,
	output logic      is_rendering,
	output logic      entering_vblank,
	output logic      exiting_vblank
);

	line_pos_t vblank_start_sl;
	line_pos_t vblank_end_sl;
	logic      skip_en;       // System allows the short line
	logic      frame_toggle;  // Flips once per frame
	logic      is_pre_render;
	logic      short_line;
	logic      end_of_line;

	always_comb begin
		case (sys_type)
			SYS_PAL: begin
				vblank_start_sl = VBLANK_START_NORMAL;
				vblank_end_sl   = VBLANK_END_LONG;
				skip_en         = 1'b0;
			end
			SYS_DENDY: begin
				vblank_start_sl = VBLANK_START_DENDY; // Long post-render gap
				vblank_end_sl   = VBLANK_END_LONG;
				skip_en         = 1'b0;
			end
			default: begin // NTSC and Vs
				vblank_start_sl = VBLANK_START_NORMAL;
				vblank_end_sl   = VBLANK_END_NTSC;
				skip_en         = 1'b1;
			end
		endcase
	end

	assign is_pre_render = (scanline == PRE_RENDER_LINE);
	assign short_line    = is_pre_render && !frame_toggle && rendering_enabled && skip_en;
	assign end_of_line   = (cycle == (short_line ? LAST_CYCLE - 9'd1 : LAST_CYCLE));

	assign entering_vblank = (cycle == 9'd0) && (scanline == vblank_start_sl);
	assign exiting_vblank  = (cycle == 9'd0) && is_pre_render;
	assign is_rendering    = rendering_enabled && ((scanline < VISIBLE_LINES) || is_pre_render);

	always_ff @(posedge clk) begin
		if (reset) begin
			cycle        <= '0;
			scanline     <= '0;
			frame_toggle <= 1'b0; // First frame is always full length
		end else begin
			cycle <= end_of_line ? 9'd0 : cycle + 9'd1;
			if (end_of_line) begin
				// 511 + 1 wraps to line 0
				scanline <= (scanline == vblank_end_sl) ? PRE_RENDER_LINE : scanline + 9'd1;
				if (scanline == 9'd255)
					frame_toggle <= ~frame_toggle;
			end
		end
	end

endmodule

// ==== verilog/ppu_vram_addr.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Temporary and current address with the shared two-write latch
// No scroll increments during rendering, data access only steps outside it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module ppu_vram_addr
	import ppu_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  byte_t   din,
	input  logic    ctrl_wr,
	input  logic    scroll_wr,
	input  logic    addr_wr,
	input  logic    data_wr,
	input  logic    data_rd,
	input  logic    status_rd,
	input  logic    incr_32,
	input  logic    is_rendering,
	output vaddr_t  vram_a,
	output fine_x_t fine_x,
	output logic    is_pal_address
);

	vaddr_t addr_t;       // Temporary address
	logic   second_write; // Latch, high after the first write of a pair

	assign is_pal_address = (vram_a[13:8] == PALETTE_PAGE);

	always_ff @(posedge clk) begin
		if (reset) begin
			vram_a       <= '0;
			addr_t       <= '0;
			fine_x       <= '0;
			second_write <= 1'b0;
		end else if (ctrl_wr) begin
			addr_t[11:10] <= din[1:0]; // Nametable select
		end else if (scroll_wr) begin
			if (!second_write) begin
				addr_t[4:0] <= din[7:3]; // Coarse X
				fine_x      <= din[2:0];
			end else begin
				addr_t[9:5]   <= din[7:3]; // Coarse Y
				addr_t[14:12] <= din[2:0]; // Fine Y
			end
			second_write <= !second_write;
		end else if (addr_wr) begin
			if (!second_write) begin
				addr_t[13:8] <= din[5:0];
				addr_t[14]   <= 1'b0;
			end else begin
				addr_t[7:0] <= din;
				vram_a      <= {addr_t[14:8], din}; // Whole address takes effect now
			end
			second_write <= !second_write;
		end else if (status_rd) begin
			second_write <= 1'b0;
		end else if ((data_wr || data_rd) && !is_rendering) begin
			vram_a <= vram_a + (incr_32 ? STEP_DOWN : STEP_ACROSS);
		end
	end

endmodule

// ==== verilog/ppu_palette_ram.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 32 x 6 colour table, contents undefined after power-up
// Entries 0x10/14/18/1C mirror 0x00/04/08/0C
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module ppu_palette_ram
	import ppu_pkg::*;
(
	input  logic       clk,
	input  pal_index_t addr,
	input  colour_t    wdata,
	input  logic       we,
	output colour_t    rdata
);

	colour_t    table_mem [PALETTE_ENTRIES];
	pal_index_t addr_fold;

	// Backdrop entries of sprite palettes share the background ones
	assign addr_fold = (addr[1:0] == 2'b00) ? {1'b0, addr[3:0]} : addr;
	assign rdata     = table_mem[addr_fold];

	always_ff @(posedge clk) begin
		if (we)
			table_mem[addr_fold] <= wdata;
	end

endmodule

// ==== verilog/ppu_status_out.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vblank flag, NMI and registered CPU read data
// Status bits 6:0 and the open bus read back as 0
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module ppu_status_out
	import ppu_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    entering_vblank,
	input  logic    exiting_vblank,
	input  logic    status_rd,
	input  logic    data_rd,
	input  logic    is_pal_address,
	input  logic    vbl_enable,
	input  colour_t colour,
	output logic    nmi,
	output byte_t   dout
);

	logic vbl_flag; // Set in vblank until read or pre-render

	assign nmi = vbl_flag && vbl_enable;

	always_ff @(posedge clk) begin
		if (reset) begin
			vbl_flag <= 1'b0;
			dout     <= '0;
		end else begin
			// Set has priority over a status read on the same edge
			if (entering_vblank)
				vbl_flag <= 1'b1;
			else if (exiting_vblank || status_rd)
				vbl_flag <= 1'b0;

			if (status_rd) begin
				dout <= {vbl_flag, 7'b0}; // Flag as it was before the read
			end else if (data_rd) begin
				// Only palette space is readable here
				dout <= is_pal_address ? {2'b00, colour} : 8'h00;
			end
		end
	end

endmodule

// ==== verilog/ppu_core.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register and timing half of the picture processor, one clock per pixel
// Read data appears one edge after the read strobe and holds until the next
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module ppu_core
	import ppu_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  sys_type_t sys_type,
	input  reg_sel_t  ain,
	input  byte_t     din,
	input  logic      read,
	input  logic      write,
	output byte_t     dout,
	output logic      nmi,
	output line_pos_t scanline,
	output line_pos_t cycle,
	output vaddr_t    vram_a,
	output fine_x_t   fine_x
);

	logic    ctrl_wr, scroll_wr, addr_wr, data_wr, data_rd, status_rd;
	logic    incr_32, vbl_enable, rendering_enabled;
	logic    is_rendering, entering_vblank, exiting_vblank;
	logic    is_pal_address;
	colour_t colour;

	ppu_reg_port u_reg_port (
		.clk               (clk),
		.reset             (reset),
		.ain               (ain),
		.din               (din),
		.read              (read),
		.write             (write),
		.ctrl_wr           (ctrl_wr),
		.scroll_wr         (scroll_wr),
		.addr_wr           (addr_wr),
		.data_wr           (data_wr),
		.data_rd           (data_rd),
		.status_rd         (status_rd),
		.incr_32           (incr_32),
		.vbl_enable        (vbl_enable),
		.rendering_enabled (rendering_enabled)
	);

	ppu_frame_timer u_frame_timer (
		.clk               (clk),
		.reset             (reset),
		.sys_type          (sys_type),
		.rendering_enabled (rendering_enabled),
		.scanline          (scanline),
		.cycle             (cycle),
		.is_rendering      (is_rendering),
		.entering_vblank   (entering_vblank),
		.exiting_vblank    (exiting_vblank)
	);

	ppu_vram_addr u_vram_addr (
		.clk            (clk),
		.reset          (reset),
		.din            (din),
		.ctrl_wr        (ctrl_wr),
		.scroll_wr      (scroll_wr),
		.addr_wr        (addr_wr),
		.data_wr        (data_wr),
		.data_rd        (data_rd),
		.status_rd      (status_rd),
		.incr_32        (incr_32),
		.is_rendering   (is_rendering),
		.vram_a         (vram_a),
		.fine_x         (fine_x),
		.is_pal_address (is_pal_address)
	);

	// Written at the address before the step
	ppu_palette_ram u_palette_ram (
		.clk   (clk),
		.addr  (vram_a[4:0]),
		.wdata (din[5:0]),
		.we    (data_wr && is_pal_address),
		.rdata (colour)
	);

	ppu_status_out u_status_out (
		.clk             (clk),
		.reset           (reset),
		.entering_vblank (entering_vblank),
		.exiting_vblank  (exiting_vblank),
		.status_rd       (status_rd),
		.data_rd         (data_rd),
		.is_pal_address  (is_pal_address),
		.vbl_enable      (vbl_enable),
		.colour          (colour),
		.nmi             (nmi),
		.dout            (dout)
	);

endmodule

// ==== tests/ppu_checker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reference model of timing, vblank flag, address latch and palette
// Compares on every rising edge, palette reads valid only after writes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module ppu_checker
	import ppu_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  sys_type_t sys_type,
	input  reg_sel_t  ain,
	input  byte_t     din,
	input  logic      read,
	input  logic      write,
	input  byte_t     dout,
	input  logic      nmi,
	input  line_pos_t scanline,
	input  line_pos_t cycle,
	input  vaddr_t    vram_a,
	input  fine_x_t   fine_x,
	output int        errors,
	output int        checks
);

	line_pos_t m_sl, m_cyc;
	logic      m_toggle, m_mask_on, m_ren, m_incr32, m_vblen, m_flag, m_latch;
	byte_t     m_dout;
	vaddr_t    m_t, m_v;
	fine_x_t   m_fx;
	colour_t   m_pal [PALETTE_ENTRIES];

	initial begin
		errors = 0;
		checks = 0;
	end

	// Backdrop entries of the upper half land on the lower half
	function automatic pal_index_t fold(input pal_index_t a);
		return (a[1:0] == 2'b00) ? {1'b0, a[3:0]} : a;
	endfunction

	task automatic check_val(input string name, input int exp, input int act);
		checks++;
		if (exp != act) begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
		end
	endtask

	always @(posedge clk) begin : model
		line_pos_t start_sl, end_sl, last;
		logic      pre, entering, exiting, rendering, pal, st_rd;
		if (reset) begin
			m_sl      = '0;
			m_cyc     = '0;
			m_toggle  = 1'b0;
			m_mask_on = 1'b0;
			m_ren     = 1'b0;
			m_incr32  = 1'b0;
			m_vblen   = 1'b0;
			m_flag    = 1'b0;
			m_latch   = 1'b0;
			m_dout    = '0;
			m_t       = '0;
			m_v       = '0;
			m_fx      = '0;
		end else begin
			// Outputs still hold the values from the previous edge here
			check_val("scanline", int'(m_sl), int'(scanline));
			check_val("cycle", int'(m_cyc), int'(cycle));
			check_val("nmi", int'(m_flag && m_vblen), int'(nmi));
			check_val("dout", int'(m_dout), int'(dout));
			check_val("vram_a", int'(m_v), int'(vram_a));
			check_val("fine_x", int'(m_fx), int'(fine_x));

			start_sl  = (sys_type == SYS_DENDY) ? VBLANK_START_DENDY : VBLANK_START_NORMAL;
			end_sl    = (sys_type == SYS_PAL || sys_type == SYS_DENDY) ?
				VBLANK_END_LONG : VBLANK_END_NTSC;
			pre       = (m_sl == PRE_RENDER_LINE);
			last      = (pre && !m_toggle && m_ren &&
				(sys_type == SYS_NTSC || sys_type == SYS_VS)) ? 9'd339 : 9'd340;
			entering  = (m_cyc == 9'd0) && (m_sl == start_sl);
			exiting   = (m_cyc == 9'd0) && pre;
			rendering = m_ren && ((m_sl < VISIBLE_LINES) || pre);
			pal       = (m_v[13:8] == PALETTE_PAGE);
			st_rd     = read && (ain == REG_STATUS);

			if (st_rd)
				m_dout = {m_flag, 7'b0}; // Flag before the read clears it
			else if (read && ain == REG_DATA)
				m_dout = pal ? {2'b00, m_pal[fold(m_v[4:0])]} : 8'h00;
			if (entering)
				m_flag = 1'b1; // Set beats a status read
			else if (exiting || st_rd)
				m_flag = 1'b0;

			if (write && ain == REG_DATA && pal)
				m_pal[fold(m_v[4:0])] = din[5:0]; // Address before the step

			m_ren = m_mask_on; // One cycle behind the mask bits
			if (write && ain == REG_MASK)
				m_mask_on = din[3] | din[4];

			if (write && ain == REG_CTRL) begin
				m_incr32    = din[2];
				m_vblen     = din[7];
				m_t[11:10]  = din[1:0];
			end else if (write && ain == REG_SCROLL) begin
				if (!m_latch) begin
					m_t[4:0] = din[7:3];
					m_fx     = din[2:0];
				end else begin
					m_t[9:5]   = din[7:3];
					m_t[14:12] = din[2:0];
				end
				m_latch = !m_latch;
			end else if (write && ain == REG_ADDR) begin
				if (!m_latch) begin
					m_t[13:8] = din[5:0];
					m_t[14]   = 1'b0;
				end else begin
					m_t[7:0] = din;
					m_v      = m_t;
				end
				m_latch = !m_latch;
			end else if (st_rd) begin
				m_latch = 1'b0;
			end else if (ain == REG_DATA && (read || write) && !rendering) begin
				m_v = m_v + (m_incr32 ? 15'd32 : 15'd1);
			end

			// Counters
			if (m_cyc == last) begin
				m_cyc = 9'd0;
				if (m_sl == 9'd255)
					m_toggle = !m_toggle;
				m_sl = (m_sl == end_sl) ? PRE_RENDER_LINE : m_sl + 9'd1;
			end else begin
				m_cyc = m_cyc + 9'd1;
			end
		end
	end

endmodule

// ==== tests/ppu_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench top, inputs change 2 ns after the rising edge
// Outputs are sampled on the falling edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module ppu_tb
	import ppu_pkg::*;
();

	// Eight PAL frames of 20 ns pixels plus 10 percent
	localparam longint WATCHDOG_NS = 64'd8 * 106392 * 20 * 11 / 10;

	logic      clk, reset, read, write, nmi;
	sys_type_t sys_type;
	reg_sel_t  ain;
	byte_t     din, dout;
	line_pos_t scanline, cycle;
	vaddr_t    vram_a;
	fine_x_t   fine_x;
	int        chk_errors, chk_checks, tb_errors;

	ppu_core u_ppu_core (.*);

	ppu_checker u_checker (
		.clk (clk), .reset (reset), .sys_type (sys_type), .ain (ain), .din (din),
		.read (read), .write (write), .dout (dout), .nmi (nmi), .scanline (scanline),
		.cycle (cycle), .vram_a (vram_a), .fine_x (fine_x),
		.errors (chk_errors), .checks (chk_checks)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired, the tests did not finish in time");
		$display("ERRORS FOUND");
		$finish;
	end

	task automatic expect_val(input string name, input int exp, input int act);
		if (exp != act) begin
			tb_errors++;
			$display("CHECK FAILED at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
		end
	endtask

	task automatic apply_reset(input sys_type_t sys);
		@(posedge clk);
		#2 reset = 1'b1;
		sys_type = sys;
		repeat (3) @(posedge clk);
		#2 reset = 1'b0;
	endtask

	// One strobe cycle on the register port
	task automatic access(input reg_sel_t sel, input byte_t data, input logic is_read);
		@(posedge clk);
		#2 ain = sel;
		din   = data;
		read  = is_read;
		write = !is_read;
		@(posedge clk);
		#2 read = 1'b0;
		write = 1'b0;
	endtask

	task automatic wait_pos(input line_pos_t sl, input line_pos_t cyc, input int limit);
		int n;
		n = 0;
		@(negedge clk);
		while (!(scanline == sl && cycle == cyc) && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (n >= limit) begin
			tb_errors++;
			$display("Scanline %0d cycle %0d not reached in %0d cycles", sl, cyc, limit);
		end
	endtask

	task automatic wait_nmi(input logic level, input int limit);
		int n;
		n = 0;
		@(negedge clk);
		while (nmi != level && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (n >= limit) begin
			tb_errors++;
			$display("nmi did not go to %0d within %0d cycles", level, limit);
		end
	endtask

	// Cycles until the next start of the pre-render line
	task automatic measure_frame(output int len);
		len = 0;
		do begin
			@(negedge clk);
			len++;
		end while (!(scanline == PRE_RENDER_LINE && cycle == 9'd0) && len < 120000);
	endtask

	task automatic run_timing(input sys_type_t sys, input line_pos_t end_sl, input logic ren);
		apply_reset(sys);
		wait_pos(end_sl, 9'd0, 120000);
		if (ren)
			access(REG_MASK, 8'h18, 1'b0); // PAL ignores rendering for line length
		wait_pos(PRE_RENDER_LINE, 9'd0, 400); // Must follow the end line directly
	endtask

	task automatic test_done(input string name);
		$display("Test %s finished, %0d errors so far", name, tb_errors + chk_errors);
	endtask

	initial begin
		int unsigned r;
		int          len_a, len_b, len_p;
		byte_t       d1, d2;
		r = $urandom(32'he50c3650);
		reset     = 1'b1;
		sys_type  = SYS_NTSC;
		ain       = '0;
		din       = '0;
		read      = 1'b0;
		write     = 1'b0;
		tb_errors = 0;

		run_timing(SYS_NTSC, VBLANK_END_NTSC, 1'b0);
		run_timing(SYS_VS, VBLANK_END_NTSC, 1'b0);
		run_timing(SYS_DENDY, VBLANK_END_LONG, 1'b0);
		run_timing(SYS_PAL, VBLANK_END_LONG, 1'b1);
		test_done("frame timing");

		measure_frame(len_p);
		expect_val("PAL frame length", 106392, len_p);
		@(posedge clk);
		#2 sys_type = SYS_NTSC;
		measure_frame(len_a);
		measure_frame(len_b);
		expect_val("NTSC frame pair length", 178683, len_a + len_b);
		expect_val("NTSC frame difference", 1, (len_a > len_b) ? len_a - len_b : len_b - len_a);
		test_done("short line");

		access(REG_MASK, 8'h00, 1'b0);
		access(REG_CTRL, 8'h80, 1'b0);
		wait_nmi(1'b1, 90000);
		expect_val("scanline at nmi rise", 241, int'(scanline));
		expect_val("cycle at nmi rise", 1, int'(cycle));
		wait_nmi(1'b0, 7000);
		expect_val("scanline at nmi fall", 511, int'(scanline));
		expect_val("cycle at nmi fall", 1, int'(cycle));
		wait_nmi(1'b1, 90000);
		access(REG_STATUS, 8'h00, 1'b1);
		@(negedge clk);
		expect_val("dout bit 7", 1, int'(dout[7]));
		expect_val("nmi after status read", 0, int'(nmi));
		test_done("vblank");

		// Fill the whole table first so every read has a known entry
		access(REG_ADDR, 8'h3F, 1'b0);
		access(REG_ADDR, 8'h00, 1'b0);
		repeat (PALETTE_ENTRIES) begin
			r = $urandom();
			access(REG_DATA, r[7:0], 1'b0);
		end
		repeat (40) begin
			r = $urandom();
			access(REG_CTRL, 8'h80 | {5'b0, r[8], 2'b0}, 1'b0); // Step 1 or 32
			access(REG_ADDR, 8'h3F, 1'b0);
			access(REG_ADDR, {3'b000, r[4:0]}, 1'b0);
			access(REG_DATA, r[23:16], r[9]);
			access(REG_DATA, r[31:24], r[10]);
			access(REG_DATA, 8'h00, 1'b1);
		end
		access(REG_ADDR, 8'h20, 1'b0);
		access(REG_ADDR, 8'h00, 1'b0);
		access(REG_DATA, 8'h00, 1'b1);
		@(negedge clk);
		expect_val("dout off the palette page", 0, int'(dout));
		test_done("palette");

		repeat (30) begin
			r  = $urandom();
			d1 = r[7:0];
			d2 = r[15:8];
			if (r[24]) begin
				access(REG_ADDR, r[23:16], 1'b0);
				access(REG_STATUS, 8'h00, 1'b1); // Drops the half-written pair
			end
			access(REG_ADDR, d1, 1'b0);
			access(REG_ADDR, d2, 1'b0);
			@(negedge clk);
			expect_val("vram_a after address pair", int'({1'b0, d1[5:0], d2}), int'(vram_a));
			access(REG_SCROLL, d2, 1'b0);
			@(negedge clk);
			expect_val("fine_x after scroll write", int'(d2[2:0]), int'(fine_x));
			access(REG_ADDR, d1, 1'b0); // Second write of the pair the scroll write opened
			@(negedge clk);
			expect_val("vram_a after scroll and address", int'({1'b0, d1[5:0], d1}),
				int'(vram_a));
		end
		test_done("address latch");

		repeat (5) @(negedge clk);
		$display("Checks %0d, errors %0d", chk_checks, tb_errors + chk_errors);
		if (tb_errors + chk_errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== tb.f ====
verilog/ppu_pkg.sv
verilog/ppu_reg_port.sv
verilog/ppu_frame_timer.sv
verilog/ppu_vram_addr.sv
verilog/ppu_palette_ram.sv
verilog/ppu_status_out.sv
verilog/ppu_core.sv
tests/ppu_checker.sv
tests/ppu_tb.sv

// ==== Makefile ====
SRCS = $(wildcard verilog/*.sv) $(wildcard tests/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vppu_tb: $(SRCS) tb.f
	verilator --binary --timing -f tb.f --top-module ppu_tb -Mdir obj_dir

run: obj_dir/Vppu_tb
	./obj_dir/Vppu_tb > sim.log 2>&1; cat sim.log
	grep -qx "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log
